/* rv_mini_core.f */
rtl/core_pkg.sv
rtl/core_ifs.sv
rtl/register_bank.sv
rtl/fetch_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/rv_mini_core.sv
testbench/core_tb_mem.sv
testbench/core_tb.sv

/* testbench/core_tb.sv */
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam word_t BOOT_ADDRESS   = 32'h0000_0000;
    localparam word_t BEQ_ADDR       = 32'h0000_0070;
    localparam word_t BEQ_TARGET     = 32'h0000_0078;
    localparam word_t JAL_TARGET     = 32'h0000_0088;
    localparam word_t MARK_BEQ       = 32'h0000_01E0;
    localparam word_t MARK_JAL       = 32'h0000_01E4;
    localparam word_t FINAL_ADDR     = 32'h0000_01FC;
    localparam int    TIMEOUT_CYCLES = 2000;
    localparam int    NUM_STORES     = 14;

    localparam word_t EXP_ADDR [NUM_STORES] = '{
        32'h100, 32'h104, 32'h108, 32'h10C, 32'h110, 32'h114, 32'h118,
        32'h11C, 32'h120, 32'h124, 32'h128, 32'h12C, 32'h130, 32'h1FC
    };
    localparam word_t EXP_DATA [NUM_STORES] = '{
        32'h0000_000C, 32'h0000_0011, 32'h0000_000C, 32'h0000_001D,
        32'h0000_000D, 32'h0000_0001, 32'h0000_0001, 32'h0000_00E1,
        32'hABCD_E000, 32'h0000_1239, 32'h0000_0000, 32'h0000_0005,
        32'h0000_0084, 32'hFFFF_FFFD
    };

    logic  clk;
    logic  rst_n;
    logic  instr_req;
    logic  instr_flush;
    logic  instr_rsp;
    word_t instr_data;
    word_t instr_addr;
    logic  data_rsp;
    word_t data_read;
    logic  data_rd;
    logic  data_wr;
    word_t data_addr;
    word_t data_write;

    logic  first_req_seen;
    word_t prev_fetch_addr;
    logic  drop_pending;
    logic  check_target;
    int    assert_errors = 0;
    int    log_errors = 0;

    core_tb_mem #(
        .SEED (22)
    ) tb_mem_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .instr_req_i  (instr_req),
        .instr_addr_i (instr_addr),
        .instr_rsp_o  (instr_rsp),
        .instr_data_o (instr_data),
        .data_rd_i    (data_rd),
        .data_wr_i    (data_wr),
        .data_addr_i  (data_addr),
        .data_write_i (data_write),
        .data_rsp_o   (data_rsp),
        .data_read_o  (data_read)
    );

    rv_mini_core #(
        .BOOT_ADDRESS (BOOT_ADDRESS)
    ) rv_mini_core_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .instr_req_o   (instr_req),
        .instr_flush_o (instr_flush),
        .instr_rsp_i   (instr_rsp),
        .instr_data_i  (instr_data),
        .instr_addr_o  (instr_addr),
        .data_rsp_i    (data_rsp),
        .data_read_i   (data_read),
        .data_rd_o     (data_rd),
        .data_wr_o     (data_wr),
        .data_addr_o   (data_addr),
        .data_write_o  (data_write)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fetch history and the drop of a flushed request
    always @(posedge clk) begin
        if (!rst_n) begin
            first_req_seen <= 1'b0;
            drop_pending   <= 1'b0;
            check_target   <= 1'b0;
        end else begin
            if (instr_req) begin
                first_req_seen  <= 1'b1;
                prev_fetch_addr <= instr_addr;
            end
            if (instr_flush && !instr_rsp) begin
                drop_pending <= 1'b1;
            end else if (drop_pending && instr_rsp) begin
                drop_pending <= 1'b0;
            end
            check_target <= (instr_flush || drop_pending) && instr_rsp;
        end
    end

    reset_quiet_a: assert property (@(posedge clk)
        !rst_n |=> !instr_req && !instr_flush && !data_rd && !data_wr)
        else begin
            assert_errors++;
            $display("A bus request or strobe was high during reset at %0t", $time);
        end

    boot_addr_a: assert property (@(posedge clk) disable iff (!rst_n)
        instr_req && !first_req_seen |-> instr_addr == BOOT_ADDRESS)
        else begin
            assert_errors++;
            $display("[FAIL] boot_address expected %h actual %h",
                     BOOT_ADDRESS, $sampled(instr_addr));
        end

    fetch_sequence_a: assert property (@(posedge clk) disable iff (!rst_n)
        instr_req && first_req_seen && prev_fetch_addr < BEQ_ADDR &&
        instr_addr != prev_fetch_addr |-> instr_addr == prev_fetch_addr + 32'd4)
        else begin
            assert_errors++;
            $display("[FAIL] fetch_sequence expected %h actual %h",
                     $sampled(prev_fetch_addr) + 32'd4, $sampled(instr_addr));
        end

    instr_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        instr_req && !instr_rsp |=> instr_req && $stable(instr_addr))
        else begin
            assert_errors++;
            $display("Instruction request dropped or moved before its response at %0t",
                     $time);
        end

    data_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (data_rd || data_wr) && !data_rsp |=> $stable(data_rd) && $stable(data_wr) &&
        $stable(data_addr) && $stable(data_write))
        else begin
            assert_errors++;
            $display("Data request changed before its response at %0t", $time);
        end

    strobes_exclusive_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_rd && data_wr))
        else begin
            assert_errors++;
            $display("Read and write strobes were high together at %0t", $time);
        end

    // Stores behind a taken beq or jal must never reach the bus
    no_marker_a: assert property (@(posedge clk) disable iff (!rst_n)
        !((data_rd || data_wr) && (data_addr == MARK_BEQ || data_addr == MARK_JAL)))
        else begin
            assert_errors++;
            $display("A flushed store reached the data bus at address %h",
                     $sampled(data_addr));
        end

    flush_target_a: assert property (@(posedge clk) disable iff (!rst_n)
        check_target |-> instr_req && (instr_addr == BEQ_TARGET || instr_addr == JAL_TARGET))
        else begin
            assert_errors++;
            $display("[FAIL] flush_target expected %h or %h actual %h",
                     BEQ_TARGET, JAL_TARGET, $sampled(instr_addr));
        end

    function automatic string store_name(input int idx);
        case (idx)
            0:       return "addi_fwd";
            1:       return "add_fwd";
            2:       return "sub_fwd";
            3:       return "xor_fwd";
            4:       return "or_fwd";
            5:       return "and_fwd";
            6:       return "slt_signed";
            7:       return "imm_logic";
            8:       return "lui";
            9:       return "load_use";
            10:      return "x0_write";
            11:      return "bne_not_taken";
            12:      return "jal_link";
            default: return "final_store";
        endcase
    endfunction

    function automatic logic final_store_logged();
        return tb_mem_i.store_addr_q.size() > 0 && tb_mem_i.store_addr_q[$] == FINAL_ADDR;
    endfunction

    task automatic compare_store_log();
        int n;
        n = tb_mem_i.store_addr_q.size();
        if (n != NUM_STORES) begin
            log_errors++;
            $display("[FAIL] store_count expected %0d actual %0d", NUM_STORES, n);
        end
        for (int i = 0; i < NUM_STORES && i < n; i++) begin
            if (tb_mem_i.store_addr_q[i] != EXP_ADDR[i]) begin
                log_errors++;
                $display("[FAIL] %s address expected %h actual %h",
                         store_name(i), EXP_ADDR[i], tb_mem_i.store_addr_q[i]);
            end
            if (tb_mem_i.store_data_q[i] != EXP_DATA[i]) begin
                log_errors++;
                $display("[FAIL] %s data expected %h actual %h",
                         store_name(i), EXP_DATA[i], tb_mem_i.store_data_q[i]);
            end
        end
    endtask

    initial begin
        int cycles;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        cycles = 0;
        while (!final_store_logged() && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!final_store_logged()) begin
            log_errors++;
            $display("Timed out after %0d cycles waiting for the store to %h",
                     cycles, FINAL_ADDR);
        end else begin
            compare_store_log();
        end
        $display("Assertion errors: %0d, store log errors: %0d", assert_errors, log_errors);
        if (assert_errors == 0 && log_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/core_tb_mem.sv */
`default_nettype none

module core_tb_mem #(
    parameter int SEED = 22
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            instr_req_i,
    input  core_pkg::word_t instr_addr_i,
    output logic            instr_rsp_o,
    output core_pkg::word_t instr_data_o,
    input  logic            data_rd_i,
    input  logic            data_wr_i,
    input  core_pkg::word_t data_addr_i,
    input  core_pkg::word_t data_write_i,
    output logic            data_rsp_o,
    output core_pkg::word_t data_read_o
);
    import core_pkg::*;

    word_t prog [$];
    word_t dmem [word_t];
    word_t store_addr_q [$];
    word_t store_data_q [$];
    int    instr_wait;
    int    data_wait;

    function automatic word_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t imm_op(input logic [2:0] f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t load_word(input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] off);
        return {off, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t store_word(input reg_addr_t rs2, input reg_addr_t rs1,
                                         input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t jump_link(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t upper_imm(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // Past the end of the program every fetch reads addi x0, x0, 0
    function automatic word_t fetch_word(input word_t addr);
        int unsigned idx;
        idx = addr >> 2;
        if (idx < prog.size()) begin
            return prog[idx];
        end
        return 32'h0000_0013;
    endfunction

    function automatic word_t read_word(input word_t addr);
        if (dmem.exists(addr)) begin
            return dmem[addr];
        end
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic load_program();
        // Base pointer, then a chain of dependent ALU operations
        prog.push_back(imm_op(3'b000, 5'd10, 5'd0, 12'h100));
        prog.push_back(imm_op(3'b000, 5'd1, 5'd0, 12'd5));
        prog.push_back(imm_op(3'b000, 5'd2, 5'd1, 12'd7));
        prog.push_back(reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        prog.push_back(reg_op(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        prog.push_back(reg_op(7'h00, 3'b100, 5'd5, 5'd4, 5'd3));
        prog.push_back(reg_op(7'h00, 3'b110, 5'd6, 5'd1, 5'd4));
        prog.push_back(reg_op(7'h00, 3'b111, 5'd7, 5'd6, 5'd3));
        prog.push_back(imm_op(3'b000, 5'd9, 5'd0, 12'hFFD));
        prog.push_back(reg_op(7'h00, 3'b010, 5'd8, 5'd9, 5'd7));
        prog.push_back(store_word(5'd2, 5'd10, 12'h000));
        prog.push_back(store_word(5'd3, 5'd10, 12'h004));
        prog.push_back(store_word(5'd4, 5'd10, 12'h008));
        prog.push_back(store_word(5'd5, 5'd10, 12'h00C));
        prog.push_back(store_word(5'd6, 5'd10, 12'h010));
        prog.push_back(store_word(5'd7, 5'd10, 12'h014));
        prog.push_back(store_word(5'd8, 5'd10, 12'h018));
        prog.push_back(imm_op(3'b100, 5'd11, 5'd3, 12'h0F0));
        prog.push_back(imm_op(3'b110, 5'd12, 5'd11, 12'h700));
        prog.push_back(imm_op(3'b111, 5'd13, 5'd12, 12'h0FF));
        prog.push_back(store_word(5'd13, 5'd10, 12'h01C));
        prog.push_back(upper_imm(5'd14, 20'hABCDE));
        prog.push_back(store_word(5'd14, 5'd10, 12'h020));
        // Load followed at once by its user
        prog.push_back(load_word(5'd15, 5'd10, 12'h080));
        prog.push_back(reg_op(7'h00, 3'b000, 5'd16, 5'd15, 5'd1));
        prog.push_back(store_word(5'd16, 5'd10, 12'h024));
        prog.push_back(imm_op(3'b000, 5'd0, 5'd0, 12'd99));
        prog.push_back(store_word(5'd0, 5'd10, 12'h028));
        // Taken beq at 0x70, the store after it targets a marker address
        prog.push_back(branch(3'b000, 5'd2, 5'd4, 13'd8));
        prog.push_back(store_word(5'd1, 5'd10, 12'h0E0));
        prog.push_back(branch(3'b001, 5'd2, 5'd4, 13'd8));
        prog.push_back(store_word(5'd1, 5'd10, 12'h02C));
        prog.push_back(jump_link(5'd17, 21'd8));
        prog.push_back(store_word(5'd1, 5'd10, 12'h0E4));
        prog.push_back(store_word(5'd17, 5'd10, 12'h030));
        prog.push_back(store_word(5'd9, 5'd10, 12'h0FC));
        dmem[32'h180] = 32'h0000_1234;
    endtask

    task automatic serve_instr();
        instr_rsp_o = 1'b0;
        if (!rst_n_i || !instr_req_i) begin
            instr_wait = -1;
        end else begin
            if (instr_wait < 0) begin
                instr_wait = int'($urandom_range(3));
            end
            if (instr_wait == 0) begin
                instr_rsp_o  = 1'b1;
                instr_data_o = fetch_word(instr_addr_i);
                instr_wait   = -1;
            end else begin
                instr_wait--;
            end
        end
    endtask

    task automatic serve_data();
        data_rsp_o = 1'b0;
        if (!rst_n_i || !(data_rd_i || data_wr_i)) begin
            data_wait = -1;
        end else begin
            if (data_wait < 0) begin
                data_wait = int'($urandom_range(3));
            end
            if (data_wait == 0) begin
                data_rsp_o = 1'b1;
                data_wait  = -1;
                if (data_wr_i) begin
                    store_addr_q.push_back(data_addr_i);
                    store_data_q.push_back(data_write_i);
                    dmem[data_addr_i] = data_write_i;
                end else begin
                    data_read_o = read_word(data_addr_i);
                end
            end else begin
                data_wait--;
            end
        end
    endtask

    // A response ends a request, a strobe still high next cycle is a new one
    initial begin
        void'($urandom(SEED));
        instr_rsp_o  = 1'b0;
        instr_data_o = '0;
        data_rsp_o   = 1'b0;
        data_read_o  = '0;
        instr_wait   = -1;
        data_wait    = -1;
        load_program();
        forever begin
            @(posedge clk);
            #1;
            serve_instr();
            serve_data();
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_mini_core.sv */
`default_nettype none

module rv_mini_core #(
    parameter core_pkg::word_t BOOT_ADDRESS = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst_n_i,

    // Instruction bus
    output logic            instr_req_o,
    output logic            instr_flush_o,
    input  logic            instr_rsp_i,
    input  core_pkg::word_t instr_data_i,
    output core_pkg::word_t instr_addr_o,

    // Data bus
    input  logic            data_rsp_i,
    input  core_pkg::word_t data_read_i,
    output logic            data_rd_o,
    output logic            data_wr_o,
    output core_pkg::word_t data_addr_o,
    output core_pkg::word_t data_write_o
);
    import core_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    fetch_if  fetch_bus ();
    ex_mem_if ex_mem_bus ();

    fetch_stage #(
        .BOOT_ADDRESS (BOOT_ADDRESS)
    ) fetch_stage_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch         (fetch_bus),
        .instr_req_o   (instr_req_o),
        .instr_flush_o (instr_flush_o),
        .instr_rsp_i   (instr_rsp_i),
        .instr_data_i  (instr_data_i),
        .instr_addr_o  (instr_addr_o)
    );

    execute_stage execute_stage_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch      (fetch_bus),
        .exm        (ex_mem_bus),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data)
    );

    memory_stage memory_stage_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .exm          (ex_mem_bus),
        .data_rsp_i   (data_rsp_i),
        .data_read_i  (data_read_i),
        .data_rd_o    (data_rd_o),
        .data_wr_o    (data_wr_o),
        .data_addr_o  (data_addr_o),
        .data_write_o (data_write_o),
        .wr_en_o      (wr_en),
        .wr_addr_o    (wr_addr),
        .wr_data_o    (wr_data)
    );

    register_bank register_bank_i (
        .clk        (clk),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

endmodule

`default_nettype wire

/* rtl/memory_stage.sv */
`default_nettype none

module memory_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    ex_mem_if.memory            exm,
    input  logic                data_rsp_i,
    input  core_pkg::word_t     data_read_i,
    output logic                data_rd_o,
    output logic                data_wr_o,
    output core_pkg::word_t     data_addr_o,
    output core_pkg::word_t     data_write_o,
    output logic                wr_en_o,
    output core_pkg::reg_addr_t wr_addr_o,
    output core_pkg::word_t     wr_data_o
);
    import core_pkg::*;

    mem_state_e state;
    reg_addr_t  m_rd;
    word_t      m_result;

    // Held until the data bus answers
    assign exm.mem_stall = (state == MEM_WAIT) && !data_rsp_i;
    assign data_addr_o   = m_result;

    // Execute to memory register, strobes raised with the entry
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state     <= MEM_IDLE;
            data_rd_o <= 1'b0;
            data_wr_o <= 1'b0;
            m_rd      <= '0;
        end else if (!exm.mem_stall) begin
            data_rd_o <= exm.valid && exm.is_load;
            data_wr_o <= exm.valid && exm.is_store;
            m_rd      <= exm.valid ? exm.rd : '0;
            if (exm.valid && (exm.is_load || exm.is_store)) begin
                state <= MEM_WAIT;
            end else begin
                state <= MEM_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!exm.mem_stall) begin
            m_result     <= exm.result;
            data_write_o <= exm.store_data;
        end
    end

    // No forward for a load, its data only exists in the response cycle
    assign exm.mem_rd     = data_rd_o ? '0 : m_rd;
    assign exm.mem_result = m_result;

    // Memory to write-back register, bubble while stalled
    always_ff @(posedge clk) begin
        if (!rst_n_i || exm.mem_stall) begin
            wr_en_o   <= 1'b0;
            wr_addr_o <= '0;
        end else begin
            wr_en_o   <= m_rd != '0;
            wr_addr_o <= m_rd;
        end
    end

    always_ff @(posedge clk) begin
        wr_data_o <= data_rd_o ? data_read_i : m_result;
    end

    assign exm.wb_rd   = wr_addr_o;
    assign exm.wb_data = wr_data_o;

    strobes_exclusive_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(data_rd_o && data_wr_o));

    data_addr_held_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        (data_rd_o || data_wr_o) && !data_rsp_i |=> $stable(data_addr_o));

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    fetch_if.execute            fetch,
    ex_mem_if.execute           exm,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i
);
    import core_pkg::*;

    word_t      ir;
    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm;
    word_t      op_a;
    word_t      rs2_val;
    word_t      alu_b;
    word_t      alu_out;
    alu_op_t    alu_op;
    logic       writes_rd;
    logic       taken;
    logic       load_use;
    reg_addr_t  load_rd_q;

    assign ir         = fetch.ir;
    assign opcode     = ir[6:0];
    assign funct3     = ir[14:12];
    assign rs1_addr_o = ir[19:15];
    assign rs2_addr_o = ir[24:20];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    // Memory stage first, then write-back, then the bank
    always_comb begin
        op_a = rs1_data_i;
        if (exm.mem_rd != '0 && exm.mem_rd == rs1_addr_o) begin
            op_a = exm.mem_result;
        end else if (exm.wb_rd != '0 && exm.wb_rd == rs1_addr_o) begin
            op_a = exm.wb_data;
        end
    end

    always_comb begin
        rs2_val = rs2_data_i;
        if (exm.mem_rd != '0 && exm.mem_rd == rs2_addr_o) begin
            rs2_val = exm.mem_result;
        end else if (exm.wb_rd != '0 && exm.wb_rd == rs2_addr_o) begin
            rs2_val = exm.wb_data;
        end
    end

    always_comb begin
        alu_op    = ALU_ADD;
        imm       = imm_i;
        writes_rd = 1'b1;
        case (opcode)
            OP_REG, OP_IMM: begin
                case (funct3)
                    3'b000: alu_op = (opcode == OP_REG && ir[30]) ? ALU_SUB : ALU_ADD;
                    3'b010: alu_op = ALU_SLT;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: writes_rd = 1'b0;
                endcase
                // SLTI is not part of the subset
                if (opcode == OP_IMM && funct3 == 3'b010) begin
                    writes_rd = 1'b0;
                end
            end
            OP_LUI: begin
                alu_op = ALU_PASS_B;
                imm    = imm_u;
            end
            OP_STORE: begin
                imm       = imm_s;
                writes_rd = 1'b0;
            end
            OP_LOAD, OP_JAL: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    assign alu_b = (opcode == OP_REG) ? rs2_val : imm;

    always_comb begin
        case (alu_op)
            ALU_SUB:    alu_out = op_a - alu_b;
            ALU_AND:    alu_out = op_a & alu_b;
            ALU_OR:     alu_out = op_a | alu_b;
            ALU_XOR:    alu_out = op_a ^ alu_b;
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = op_a + alu_b;
        endcase
    end

    assign taken = (opcode == OP_JAL) ||
                   (opcode == OP_BRANCH && funct3 == 3'b000 && op_a == rs2_val) ||
                   (opcode == OP_BRANCH && funct3 == 3'b001 && op_a != rs2_val);

    // Load in the memory stage feeding either source field
    assign load_use = fetch.valid && load_rd_q != '0 &&
                      (load_rd_q == rs1_addr_o || load_rd_q == rs2_addr_o);

    assign fetch.stall    = load_use || exm.mem_stall;
    assign fetch.redirect = fetch.valid && taken && !fetch.stall;
    assign fetch.target   = fetch.pc + ((opcode == OP_JAL) ? imm_j : imm_b);

    assign exm.valid      = fetch.valid && !load_use;
    assign exm.is_load    = opcode == OP_LOAD;
    assign exm.is_store   = opcode == OP_STORE;
    assign exm.rd         = writes_rd ? ir[11:7] : '0;
    assign exm.result     = (opcode == OP_JAL) ? fetch.pc + 32'd4 : alu_out;
    assign exm.store_data = rs2_val;

    // Tracks the load now held in the memory stage
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            load_rd_q <= '0;
        end else if (!exm.mem_stall) begin
            load_rd_q <= (exm.valid && exm.is_load) ? exm.rd : '0;
        end
    end

    load_use_single_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        load_use && !exm.mem_stall |=> !load_use);

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`default_nettype none

module fetch_stage #(
    parameter core_pkg::word_t BOOT_ADDRESS = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst_n_i,
    fetch_if.fetch          fetch,
    output logic            instr_req_o,
    output logic            instr_flush_o,
    input  logic            instr_rsp_i,
    input  core_pkg::word_t instr_data_i,
    output core_pkg::word_t instr_addr_o
);
    import core_pkg::*;

    fetch_state_e state;
    word_t        pc;
    logic         accept;

    // A response is only kept when the decode register can take it
    assign accept = (state == FETCH_WAIT) && instr_rsp_i && !fetch.stall && !fetch.redirect;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state         <= FETCH_IDLE;
            pc            <= BOOT_ADDRESS;
            instr_req_o   <= 1'b0;
            instr_flush_o <= 1'b0;
        end else begin
            instr_flush_o <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    instr_req_o  <= 1'b1;
                    instr_addr_o <= pc;
                    state        <= FETCH_WAIT;
                end
                FETCH_WAIT: begin
                    if (fetch.redirect) begin
                        pc <= fetch.target;
                        if (instr_rsp_i) begin
                            instr_addr_o <= fetch.target;
                        end else begin
                            instr_flush_o <= 1'b1;
                            state         <= FETCH_DROP;
                        end
                    end else if (accept) begin
                        pc           <= pc + 32'd4;
                        instr_addr_o <= pc + 32'd4;
                    end
                    // Response under stall is dropped, same address asked again
                end
                FETCH_DROP: begin
                    if (instr_rsp_i) begin
                        instr_addr_o <= pc;
                        state        <= FETCH_WAIT;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // Fetch to execute register
    always_ff @(posedge clk) begin
        if (!rst_n_i || fetch.redirect) begin
            fetch.valid <= 1'b0;
        end else if (!fetch.stall) begin
            fetch.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fetch.pc <= instr_addr_o;
            fetch.ir <= instr_data_i;
        end
    end

    addr_held_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        instr_req_o && !instr_rsp_i |=> $stable(instr_addr_o));

endmodule

`default_nettype wire

/* rtl/register_bank.sv */
`default_nettype none

module register_bank (
    input  logic                clk,
    input  logic                wr_en_i,
    input  core_pkg::reg_addr_t wr_addr_i,
    input  core_pkg::word_t     wr_data_i,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o
);
    import core_pkg::*;

    word_t regs [1:31];

    // Write-first read, x0 hardwired
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en_i && wr_addr_i == addr) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    always_ff @(posedge clk) begin
        if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    no_x0_write_a: assert property (@(posedge clk) wr_en_i |-> wr_addr_i != '0);

endmodule

`default_nettype wire

/* rtl/core_ifs.sv */
`default_nettype none

interface fetch_if;
    import core_pkg::*;

    logic  valid;
    word_t pc;
    word_t ir;
    logic  stall;
    logic  redirect;
    word_t target;

    modport fetch (
        output valid, pc, ir,
        input  stall, redirect, target
    );
    modport execute (
        input  valid, pc, ir,
        output stall, redirect, target
    );
endinterface

interface ex_mem_if;
    import core_pkg::*;

    logic      valid;
    logic      is_load;
    logic      is_store;
    reg_addr_t rd;
    word_t     result;
    word_t     store_data;
    logic      mem_stall;
    reg_addr_t mem_rd;
    word_t     mem_result;
    reg_addr_t wb_rd;
    word_t     wb_data;

    modport execute (
        output valid, is_load, is_store, rd, result, store_data,
        input  mem_stall, mem_rd, mem_result, wb_rd, wb_data
    );
    modport memory (
        input  valid, is_load, is_store, rd, result, store_data,
        output mem_stall, mem_rd, mem_result, wb_rd, wb_data
    );
endinterface

`default_nettype wire

/* rtl/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_op_t;

    // ALU operation select
    localparam alu_op_t ALU_ADD    = 3'd0;
    localparam alu_op_t ALU_SUB    = 3'd1;
    localparam alu_op_t ALU_AND    = 3'd2;
    localparam alu_op_t ALU_OR     = 3'd3;
    localparam alu_op_t ALU_XOR    = 3'd4;
    localparam alu_op_t ALU_SLT    = 3'd5;
    localparam alu_op_t ALU_PASS_B = 3'd6;

    // RV32I major opcodes of the supported subset
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // Instruction bus machine, DROP swallows the answer to a flushed request
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_DROP
    } fetch_state_e;

    // Data bus machine
    typedef enum logic {
        MEM_IDLE,
        MEM_WAIT
    } mem_state_e;

endpackage

`default_nettype wire
